//--- rv32i_isa_pkg.sv
// RV32I base encodings
package rv32i_isa_pkg;

  // Major opcodes
  localparam logic [6:0] OPCODE_OPIMM  = 7'b0010011;
  localparam logic [6:0] OPCODE_OP     = 7'b0110011;
  localparam logic [6:0] OPCODE_LUI    = 7'b0110111;
  localparam logic [6:0] OPCODE_LOAD   = 7'b0000011;
  localparam logic [6:0] OPCODE_STORE  = 7'b0100011;
  localparam logic [6:0] OPCODE_BRANCH = 7'b1100011;
  localparam logic [6:0] OPCODE_JAL    = 7'b1101111;
  localparam logic [6:0] OPCODE_JALR   = 7'b1100111;
  localparam logic [6:0] OPCODE_SYSTEM = 7'b1110011;

  // funct3 codes for the ops the expanders produce
  localparam logic [2:0] F3_ADD     = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_LW      = 3'b010;
  localparam logic [2:0] F3_SW      = 3'b010;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA

  // Fixed registers
  localparam logic [4:0] REG_ZERO = 5'd0;
  localparam logic [4:0] REG_RA   = 5'd1;
  localparam logic [4:0] REG_SP   = 5'd2;

  // EBREAK has funct12 = 1, all register fields zero
  localparam logic [31:0] INSTR_EBREAK = {12'h001, 5'd0, 3'b000, 5'd0, OPCODE_SYSTEM};

endpackage

//--- rvc_pkg.sv
// RVC compressed formats
package rvc_pkg;

  // Low two bits of the fetch word
  localparam logic [1:0] QUAD_0    = 2'b00;
  localparam logic [1:0] QUAD_1    = 2'b01;
  localparam logic [1:0] QUAD_2    = 2'b10;
  localparam logic [1:0] QUAD_FULL = 2'b11; // 32-bit instruction

  // Quadrant 0
  localparam logic [2:0] CF3_ADDI4SPN = 3'b000;
  localparam logic [2:0] CF3_LW       = 3'b010;
  localparam logic [2:0] CF3_SW       = 3'b110;
  // Quadrant 1
  localparam logic [2:0] CF3_ADDI     = 3'b000;
  localparam logic [2:0] CF3_JAL      = 3'b001;
  localparam logic [2:0] CF3_LI       = 3'b010;
  localparam logic [2:0] CF3_LUI      = 3'b011; // also C.ADDI16SP
  localparam logic [2:0] CF3_MISC_ALU = 3'b100;
  localparam logic [2:0] CF3_J        = 3'b101;
  localparam logic [2:0] CF3_BEQZ     = 3'b110;
  localparam logic [2:0] CF3_BNEZ     = 3'b111;
  // Quadrant 2
  localparam logic [2:0] CF3_SLLI     = 3'b000;
  localparam logic [2:0] CF3_LWSP     = 3'b010;
  localparam logic [2:0] CF3_CR       = 3'b100; // JR, MV, EBREAK, JALR, ADD
  localparam logic [2:0] CF3_SWSP     = 3'b110;

  // Upper bits of x8..x15 for the 3-bit register fields
  localparam logic [1:0] RVC_PRIME_BASE = 2'b01;

  typedef struct packed {
    logic [3:0] funct4;
    logic [4:0] rd_rs1;
    logic [4:0] rs2;
    logic [1:0] op;
  } rvc_cr_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;  // Bit 12
    logic [4:0] rd_rs1;
    logic [4:0] imm_lo;  // Bits 6:2
    logic [1:0] op;
  } rvc_ci_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [5:0] imm;
    logic [4:0] rs2;
    logic [1:0] op;
  } rvc_css_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [7:0] imm;
    logic [2:0] rd_p;
    logic [1:0] op;
  } rvc_ciw_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;
    logic [2:0] rs1_p;
    logic [1:0] imm_lo;
    logic [2:0] rd_p;
    logic [1:0] op;
  } rvc_cl_t;

  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;
    logic [2:0] rs1_p;
    logic [1:0] imm_lo;
    logic [2:0] rs2_p;
    logic [1:0] op;
  } rvc_cs_t;

  typedef struct packed {
    logic [5:0] funct6;
    logic [2:0] rd_rs1_p;
    logic [1:0] funct2;
    logic [2:0] rs2_p;
    logic [1:0] op;
  } rvc_ca_t;

  // Branches use imm_hi and funct2 as offset bits
  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;
    logic [1:0] funct2;
    logic [2:0] rs1_p;
    logic [4:0] imm_lo;
    logic [1:0] op;
  } rvc_cb_t;

  typedef struct packed {
    logic [2:0]  funct3;
    logic [10:0] target;
    logic [1:0]  op;
  } rvc_cj_t;

  typedef union packed {
    rvc_cr_t  cr;
    rvc_ci_t  ci;
    rvc_css_t css;
    rvc_ciw_t ciw;
    rvc_cl_t  cl;
    rvc_cs_t  cs;
    rvc_ca_t  ca;
    rvc_cb_t  cb;
    rvc_cj_t  cj;
  } rvc_instr_u;

endpackage

//--- rvc_quadrant0_expander.sv
// RVC quadrant 0 expander
module rvc_quadrant0_expander
  import rv32i_isa_pkg::*, rvc_pkg::*;
(
  input  rvc_instr_u  cinstr_i,
  output logic [31:0] instr_o,
  output logic        illegal_o
);

  logic [11:0] addi4spn_imm;
  logic [6:0]  word_off;     // Shared by C.LW and C.SW

  // nzuimm[5:4|9:6|2|3] sits in bits 12:5
  assign addi4spn_imm = {2'b00, cinstr_i.ciw.imm[5:2], cinstr_i.ciw.imm[7:6],
                         cinstr_i.ciw.imm[0], cinstr_i.ciw.imm[1], 2'b00};
  assign word_off     = {cinstr_i.cl.imm_lo[0], cinstr_i.cl.imm_hi,
                         cinstr_i.cl.imm_lo[1], 2'b00};

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;
    case (cinstr_i.ciw.funct3)
      CF3_ADDI4SPN: begin
        if (cinstr_i.ciw.imm == 8'd0) begin
          illegal_o = 1'b1; // Also covers the all-zero halfword
        end else begin
          instr_o = {addi4spn_imm, REG_SP, F3_ADD,
                     RVC_PRIME_BASE, cinstr_i.ciw.rd_p, OPCODE_OPIMM};
        end
      end
      CF3_LW: begin
        instr_o = {5'b0, word_off, RVC_PRIME_BASE, cinstr_i.cl.rs1_p, F3_LW,
                   RVC_PRIME_BASE, cinstr_i.cl.rd_p, OPCODE_LOAD};
      end
      CF3_SW: begin
        instr_o = {5'b0, word_off[6:5], RVC_PRIME_BASE, cinstr_i.cs.rs2_p,
                   RVC_PRIME_BASE, cinstr_i.cs.rs1_p, F3_SW, word_off[4:0], OPCODE_STORE};
      end
      default: illegal_o = 1'b1; // FP forms and reserved
    endcase
  end

endmodule

//--- rvc_quadrant1_expander.sv
// RVC quadrant 1 expander
module rvc_quadrant1_expander
  import rv32i_isa_pkg::*, rvc_pkg::*;
(
  input  rvc_instr_u  cinstr_i,
  output logic [31:0] instr_o,
  output logic        illegal_o
);

  logic [11:0] ci_imm;      // Sign-extended 6-bit immediate
  logic [5:0]  ci_imm6;
  logic [11:0] addi16sp_imm;
  logic [20:0] j_off;
  logic [12:0] b_off;
  logic [4:0]  rd_p;
  logic [4:0]  rs2_p;
  logic [4:0]  jal_rd;
  logic [2:0]  br_f3;

  assign ci_imm6 = {cinstr_i.ci.imm_hi, cinstr_i.ci.imm_lo};
  assign ci_imm  = {{6{cinstr_i.ci.imm_hi}}, ci_imm6};

  // nzimm[9|4|6|8:7|5] from bits 12 and 6:2
  assign addi16sp_imm = {{3{cinstr_i.ci.imm_hi}}, cinstr_i.ci.imm_lo[2:1],
                         cinstr_i.ci.imm_lo[3], cinstr_i.ci.imm_lo[0],
                         cinstr_i.ci.imm_lo[4], 4'b0000};

  // offset[11|4|9:8|10|6|7|3:1|5]
  assign j_off = {{9{cinstr_i.cj.target[10]}}, cinstr_i.cj.target[10],
                  cinstr_i.cj.target[6], cinstr_i.cj.target[8:7],
                  cinstr_i.cj.target[4], cinstr_i.cj.target[5],
                  cinstr_i.cj.target[0], cinstr_i.cj.target[9],
                  cinstr_i.cj.target[3:1], 1'b0};

  // offset[8|4:3] in 12:10, [7:6|2:1|5] in 6:2
  assign b_off = {{4{cinstr_i.cb.imm_hi}}, cinstr_i.cb.imm_hi,
                  cinstr_i.cb.imm_lo[4:3], cinstr_i.cb.imm_lo[0],
                  cinstr_i.cb.funct2, cinstr_i.cb.imm_lo[2:1], 1'b0};

  assign rd_p   = {RVC_PRIME_BASE, cinstr_i.cb.rs1_p};
  assign rs2_p  = {RVC_PRIME_BASE, cinstr_i.ca.rs2_p};
  assign jal_rd = (cinstr_i.cj.funct3 == CF3_JAL) ? REG_RA : REG_ZERO;
  assign br_f3  = (cinstr_i.cb.funct3 == CF3_BNEZ) ? F3_BNE : F3_BEQ;

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;
    case (cinstr_i.ci.funct3)
      CF3_ADDI: begin
        instr_o = {ci_imm, cinstr_i.ci.rd_rs1, F3_ADD, cinstr_i.ci.rd_rs1, OPCODE_OPIMM};
      end
      CF3_LI: begin
        instr_o = {ci_imm, REG_ZERO, F3_ADD, cinstr_i.ci.rd_rs1, OPCODE_OPIMM};
      end
      CF3_JAL, CF3_J: begin
        instr_o = {j_off[20], j_off[10:1], j_off[11], j_off[19:12], jal_rd, OPCODE_JAL};
      end
      CF3_LUI: begin
        if (ci_imm6 == 6'd0 || cinstr_i.ci.rd_rs1 == REG_ZERO) begin
          illegal_o = 1'b1;
        end else if (cinstr_i.ci.rd_rs1 == REG_SP) begin
          instr_o = {addi16sp_imm, REG_SP, F3_ADD, REG_SP, OPCODE_OPIMM}; // C.ADDI16SP
        end else begin
          instr_o = {{14{cinstr_i.ci.imm_hi}}, ci_imm6, cinstr_i.ci.rd_rs1, OPCODE_LUI};
        end
      end
      CF3_MISC_ALU: begin
        case (cinstr_i.cb.funct2)
          2'b00, 2'b01: begin
            if (cinstr_i.cb.imm_hi) begin
              illegal_o = 1'b1; // shamt[5] is RV64 only
            end else begin
              instr_o = {cinstr_i.cb.funct2[0] ? F7_ALT : F7_BASE, cinstr_i.cb.imm_lo,
                         rd_p, F3_SRL_SRA, rd_p, OPCODE_OPIMM};
            end
          end
          2'b10: instr_o = {ci_imm, rd_p, F3_AND, rd_p, OPCODE_OPIMM}; // C.ANDI
          default: begin
            if (cinstr_i.ca.funct6[2]) begin
              illegal_o = 1'b1; // SUBW, ADDW and reserved
            end else begin
              case (cinstr_i.ca.funct2)
                2'b00:   instr_o = {F7_ALT, rs2_p, rd_p, F3_ADD, rd_p, OPCODE_OP};
                2'b01:   instr_o = {F7_BASE, rs2_p, rd_p, F3_XOR, rd_p, OPCODE_OP};
                2'b10:   instr_o = {F7_BASE, rs2_p, rd_p, F3_OR, rd_p, OPCODE_OP};
                default: instr_o = {F7_BASE, rs2_p, rd_p, F3_AND, rd_p, OPCODE_OP};
              endcase
            end
          end
        endcase
      end
      CF3_BEQZ, CF3_BNEZ: begin
        instr_o = {b_off[12], b_off[10:5], REG_ZERO, rd_p, br_f3,
                   b_off[4:1], b_off[11], OPCODE_BRANCH};
      end
    endcase
  end

endmodule

//--- rvc_quadrant2_expander.sv
// RVC quadrant 2 expander
module rvc_quadrant2_expander
  import rv32i_isa_pkg::*, rvc_pkg::*;
(
  input  rvc_instr_u  cinstr_i,
  output logic [31:0] instr_o,
  output logic        illegal_o
);

  logic [11:0] lwsp_imm;
  logic [4:0]  rd;
  logic [4:0]  rs2;

  // offset[5] in bit 12, offset[4:2|7:6] in 6:2
  assign lwsp_imm = {4'b0000, cinstr_i.ci.imm_lo[1:0], cinstr_i.ci.imm_hi,
                     cinstr_i.ci.imm_lo[4:2], 2'b00};
  assign rd       = cinstr_i.cr.rd_rs1;
  assign rs2      = cinstr_i.cr.rs2;

  always_comb begin
    instr_o   = '0;
    illegal_o = 1'b0;
    case (cinstr_i.ci.funct3)
      CF3_SLLI: begin
        if (cinstr_i.ci.imm_hi) begin
          illegal_o = 1'b1;
        end else begin
          instr_o = {F7_BASE, cinstr_i.ci.imm_lo, rd, F3_SLL, rd, OPCODE_OPIMM};
        end
      end
      CF3_LWSP: begin
        if (rd == REG_ZERO) illegal_o = 1'b1;
        else instr_o = {lwsp_imm, REG_SP, F3_LW, rd, OPCODE_LOAD};
      end
      CF3_SWSP: begin
        // offset[5:2|7:6] in bits 12:7
        instr_o = {4'b0000, cinstr_i.css.imm[1:0], cinstr_i.css.imm[5], cinstr_i.css.rs2,
                   REG_SP, F3_SW, cinstr_i.css.imm[4:2], 2'b00, OPCODE_STORE};
      end
      CF3_CR: begin
        if (!cinstr_i.cr.funct4[0]) begin
          if (rs2 != REG_ZERO) begin
            instr_o = {F7_BASE, rs2, REG_ZERO, F3_ADD, rd, OPCODE_OP}; // C.MV
          end else if (rd == REG_ZERO) begin
            illegal_o = 1'b1;
          end else begin
            instr_o = {12'd0, rd, 3'b000, REG_ZERO, OPCODE_JALR};      // C.JR
          end
        end else begin
          if (rs2 != REG_ZERO) begin
            instr_o = {F7_BASE, rs2, rd, F3_ADD, rd, OPCODE_OP};       // C.ADD
          end else if (rd == REG_ZERO) begin
            instr_o = INSTR_EBREAK;
          end else begin
            instr_o = {12'd0, rd, 3'b000, REG_RA, OPCODE_JALR};        // C.JALR
          end
        end
      end
      default: illegal_o = 1'b1; // FP stack forms
    endcase
  end

endmodule

//--- rvc_expander.sv
// RVC expander by quadrant
module rvc_expander
  import rvc_pkg::*;
(
  input  logic [31:0] instr_i,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  rvc_instr_u  cinstr;
  logic [31:0] q0_instr, q1_instr, q2_instr;
  logic        q0_illegal, q1_illegal, q2_illegal;

  assign cinstr = instr_i[15:0];

  rvc_quadrant0_expander u_q0 (.cinstr_i(cinstr), .instr_o(q0_instr), .illegal_o(q0_illegal));
  rvc_quadrant1_expander u_q1 (.cinstr_i(cinstr), .instr_o(q1_instr), .illegal_o(q1_illegal));
  rvc_quadrant2_expander u_q2 (.cinstr_i(cinstr), .instr_o(q2_instr), .illegal_o(q2_illegal));

  assign is_compressed_o = (cinstr.cr.op != QUAD_FULL);

  always_comb begin
    case (cinstr.cr.op)
      QUAD_0: begin
        instr_o   = q0_instr;
        illegal_o = q0_illegal;
      end
      QUAD_1: begin
        instr_o   = q1_instr;
        illegal_o = q1_illegal;
      end
      QUAD_2: begin
        instr_o   = q2_instr;
        illegal_o = q2_illegal;
      end
      default: begin
        instr_o   = instr_i; // Full word passes through
        illegal_o = 1'b0;
      end
    endcase
  end

endmodule

//--- rvc_decode_stage.sv
// Registered RVC decode stage
module rvc_decode_stage (
  input  logic        clk_i,
  input  logic        arst_n_i,
  input  logic        valid_i,
  input  logic [31:0] instr_i,
  output logic        valid_o,
  output logic [31:0] instr_o,
  output logic        is_compressed_o,
  output logic        illegal_o
);

  logic [31:0] exp_instr;
  logic        exp_compressed;
  logic        exp_illegal;

  rvc_expander u_expander (
    .instr_i        (instr_i),
    .instr_o        (exp_instr),
    .is_compressed_o(exp_compressed),
    .illegal_o      (exp_illegal)
  );

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      valid_o         <= 1'b0;
      instr_o         <= '0;
      is_compressed_o <= 1'b0;
      illegal_o       <= 1'b0;
    end else begin
      valid_o <= valid_i;
      if (valid_i) begin // Hold result between accepted words
        instr_o         <= exp_instr;
        is_compressed_o <= exp_compressed;
        illegal_o       <= exp_illegal;
      end
    end
  end

endmodule

//--- tb_rvc_model.svh
// Reference RVC expansion
`ifndef TB_RVC_MODEL_SVH
`define TB_RVC_MODEL_SVH

// Result is {illegal, compressed, expanded word}
function automatic logic [33:0] expand_rvc(input logic [31:0] w);
  logic [15:0] h;
  logic [4:0]  rd;
  logic [4:0]  rs2;
  logic [4:0]  rp_lo;  // Bits 4:2 as x8..x15
  logic [4:0]  rp_hi;  // Bits 9:7 as x8..x15
  logic [11:0] imm;
  logic [20:0] joff;
  logic [12:0] boff;
  logic [31:0] ins;
  logic        ill;
  h     = w[15:0];
  rd    = h[11:7];
  rs2   = h[6:2];
  rp_lo = {2'b01, h[4:2]};
  rp_hi = {2'b01, h[9:7]};
  imm   = {{6{h[12]}}, h[12], h[6:2]};
  joff  = {{9{h[12]}}, h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
  boff  = {{4{h[12]}}, h[12], h[6:5], h[2], h[11:10], h[4:3], 1'b0};
  ins   = '0;
  ill   = 1'b0;
  if (h[1:0] == QUAD_FULL) return {2'b00, w};
  if (h[1:0] == QUAD_0) begin
    case (h[15:13])
      3'b000: begin
        if (h[12:5] == 8'd0) ill = 1'b1;
        else ins = {2'b00, h[10:7], h[12:11], h[5], h[6], 2'b00, REG_SP, F3_ADD, rp_lo,
                    OPCODE_OPIMM};
      end
      3'b010: ins = {5'd0, h[5], h[12:10], h[6], 2'b00, rp_hi, F3_LW, rp_lo, OPCODE_LOAD};
      3'b110: ins = {5'd0, h[5], h[12], rp_lo, rp_hi, F3_SW, h[11:10], h[6], 2'b00,
                     OPCODE_STORE};
      default: ill = 1'b1;
    endcase
  end else if (h[1:0] == QUAD_1) begin
    case (h[15:13])
      3'b000: ins = {imm, rd, F3_ADD, rd, OPCODE_OPIMM};
      3'b001, 3'b101: ins = {joff[20], joff[10:1], joff[11], joff[19:12],
                             h[15] ? REG_ZERO : REG_RA, OPCODE_JAL};
      3'b010: ins = {imm, REG_ZERO, F3_ADD, rd, OPCODE_OPIMM};
      3'b011: begin
        if ({h[12], h[6:2]} == 6'd0 || rd == REG_ZERO) ill = 1'b1;
        else if (rd == REG_SP) ins = {{3{h[12]}}, h[4:3], h[5], h[2], h[6], 4'b0000,
                                      REG_SP, F3_ADD, REG_SP, OPCODE_OPIMM};
        else ins = {{14{h[12]}}, h[12], h[6:2], rd, OPCODE_LUI};
      end
      3'b100: begin
        case (h[11:10])
          2'b00, 2'b01: begin
            if (h[12]) ill = 1'b1;  // RV64 shift amount
            else ins = {h[10] ? F7_ALT : F7_BASE, h[6:2], rp_hi, F3_SRL_SRA, rp_hi,
                        OPCODE_OPIMM};
          end
          2'b10: ins = {imm, rp_hi, F3_AND, rp_hi, OPCODE_OPIMM};
          default: begin
            if (h[12]) ill = 1'b1;
            else if (h[6:5] == 2'b00) ins = {F7_ALT, rp_lo, rp_hi, F3_ADD, rp_hi, OPCODE_OP};
            else if (h[6:5] == 2'b01) ins = {F7_BASE, rp_lo, rp_hi, F3_XOR, rp_hi, OPCODE_OP};
            else if (h[6:5] == 2'b10) ins = {F7_BASE, rp_lo, rp_hi, F3_OR, rp_hi, OPCODE_OP};
            else ins = {F7_BASE, rp_lo, rp_hi, F3_AND, rp_hi, OPCODE_OP};
          end
        endcase
      end
      default: ins = {boff[12], boff[10:5], REG_ZERO, rp_hi, h[13] ? F3_BNE : F3_BEQ,
                      boff[4:1], boff[11], OPCODE_BRANCH};
    endcase
  end else begin
    case (h[15:13])
      3'b000: begin
        if (h[12]) ill = 1'b1;
        else ins = {F7_BASE, h[6:2], rd, F3_SLL, rd, OPCODE_OPIMM};
      end
      3'b010: begin
        if (rd == REG_ZERO) ill = 1'b1;
        else ins = {4'd0, h[3:2], h[12], h[6:4], 2'b00, REG_SP, F3_LW, rd, OPCODE_LOAD};
      end
      3'b100: begin
        if (rs2 != REG_ZERO) ins = {F7_BASE, rs2, h[12] ? rd : REG_ZERO, F3_ADD, rd, OPCODE_OP};
        else if (rd != REG_ZERO) ins = {12'd0, rd, 3'b000, h[12] ? REG_RA : REG_ZERO,
                                        OPCODE_JALR};
        else if (h[12]) ins = INSTR_EBREAK;
        else ill = 1'b1;  // C.JR with rs1 zero
      end
      3'b110: ins = {4'd0, h[8:7], h[12], rs2, REG_SP, F3_SW, h[11:9], 2'b00, OPCODE_STORE};
      default: ill = 1'b1;
    endcase
  end
  if (ill) ins = '0;
  return {ill, 1'b1, ins};
endfunction

`endif

//--- tb_rvc_decode_stage.sv
// RVC decode stage testbench
module tb_rvc_decode_stage
  import rv32i_isa_pkg::*, rvc_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PERIOD       = 40;
  localparam int RESET_CYCLES = 2;
  localparam int N_RANDOM     = 500;
  localparam int N_DIRECTED   = 120;  // Directed words and idle gaps, upper bound
  localparam int TIMEOUT_NS   = 2 * (N_DIRECTED + N_RANDOM + RESET_CYCLES) * PERIOD;

  logic        clk_i;
  logic        arst_n_i;
  logic        valid_i;
  logic [31:0] instr_i;
  logic        valid_o;
  logic [31:0] instr_o;
  logic        is_compressed_o;
  logic        illegal_o;

  logic [33:0] exp_q[$];  // {illegal, compressed, word}
  logic [33:0] head;
  logic        exp_valid;
  logic [31:0] exp_instr;
  logic        exp_comp;
  logic        exp_ill;
  logic [31:0] lcg_state;
  int          value_errs;
  int          other_errs;
  logic [15:0] legal_hw[$];
  logic [15:0] illegal_hw[$];

  `include "tb_rvc_model.svh"

  rvc_decode_stage u_dut (
    .clk_i          (clk_i),
    .arst_n_i       (arst_n_i),
    .valid_i        (valid_i),
    .instr_i        (instr_i),
    .valid_o        (valid_o),
    .instr_o        (instr_o),
    .is_compressed_o(is_compressed_o),
    .illegal_o      (illegal_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // Expected outputs, one cycle behind each accepted word
  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      exp_valid <= 1'b0;
      exp_instr <= '0;
      exp_comp  <= 1'b0;
      exp_ill   <= 1'b0;
    end else begin
      exp_valid <= valid_i;
      if (valid_i) begin
        if (exp_q.size() == 0) begin
          other_errs++;
          $display("A word was accepted with no expected result queued at %0t", $time);
        end else begin
          head = exp_q.pop_front();
          {exp_ill, exp_comp, exp_instr} <= head;
        end
      end
    end
  end

  a_valid: assert property (@(posedge clk_i) disable iff (!arst_n_i) valid_o == exp_valid)
    else begin
      value_errs++;
      $display("error %0t: valid_o %0b, expected %0b", $time, $sampled(valid_o),
               $sampled(exp_valid));
    end
  a_instr: assert property (@(posedge clk_i) disable iff (!arst_n_i) instr_o == exp_instr)
    else begin
      value_errs++;
      $display("error %0t: instr_o %08h, expected %08h", $time, $sampled(instr_o),
               $sampled(exp_instr));
    end
  a_comp: assert property (@(posedge clk_i) disable iff (!arst_n_i) is_compressed_o == exp_comp)
    else begin
      value_errs++;
      $display("error %0t: is_compressed_o %0b, expected %0b", $time,
               $sampled(is_compressed_o), $sampled(exp_comp));
    end
  a_ill: assert property (@(posedge clk_i) disable iff (!arst_n_i) illegal_o == exp_ill)
    else begin
      value_errs++;
      $display("error %0t: illegal_o %0b, expected %0b", $time, $sampled(illegal_o),
               $sampled(exp_ill));
    end
  // Illegal results carry a zero word and are always compressed
  a_ill_zero: assert property (@(posedge clk_i) disable iff (!arst_n_i)
                               illegal_o |-> (instr_o == 32'd0 && is_compressed_o))
    else begin
      value_errs++;
      $display("error %0t: illegal result with instr_o %08h", $time, $sampled(instr_o));
    end

  task automatic send_word(input logic [31:0] w);
    @(posedge clk_i);
    valid_i <= 1'b1;
    instr_i <= w;
    exp_q.push_back(expand_rvc(w));
  endtask

  // Junk on instr_i must not reach the outputs
  task automatic idle_cycles(input int n);
    logic [31:0] r;
    repeat (n) begin
      @(posedge clk_i);
      r = lcg_next();
      valid_i <= 1'b0;
      instr_i <= r;
    end
  endtask

  task automatic report_and_finish();
    $display("Errors: %0d value, %0d other", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  endtask

  initial begin
    #(TIMEOUT_NS);
    other_errs++;
    $display("Timeout: the run did not finish within %0d ns", TIMEOUT_NS);
    report_and_finish();
  end

  initial begin
    logic [31:0] r;
    logic [31:0] w;
    arst_n_i   = 1'b0;
    valid_i    = 1'b0;
    instr_i    = '0;
    lcg_state  = 32'd25;
    value_errs = 0;
    other_errs = 0;
    legal_hw   = '{16'h1FE0, 16'h4E7C, 16'hD54C, 16'h0001, 16'h12FD, 16'h457D, 16'h3FFD,
                   16'h2005, 16'hA0F5, 16'hBFFD, 16'h7385, 16'h717D, 16'h6141, 16'h8195,
                   16'h8595, 16'h99F1, 16'h8C89, 16'h8CA9, 16'h8CC9, 16'h8CE9, 16'hDE7D,
                   16'hE529, 16'h049E, 16'h50FE, 16'hDFFE, 16'h8082, 16'h8192, 16'h9002,
                   16'h9282, 16'h931E};
    illegal_hw = '{16'h0000, 16'h001C, 16'h2398, 16'h8000, 16'hA398, 16'hE398, 16'h6381,
                   16'h6101, 16'h6005, 16'h9195, 16'h9595, 16'h9C89, 16'h9CA9, 16'h9CC9,
                   16'h9CE9, 16'h149E, 16'h507E, 16'h8002, 16'h2082, 16'hA082};
    repeat (RESET_CYCLES) @(posedge clk_i);
    arst_n_i <= 1'b1;
    idle_cycles(2);  // Outputs stay zero
    send_word(32'h0050_0093);
    send_word(32'hFFFF_FFFF);
    send_word(32'h1234_5677);
    idle_cycles(1);
    foreach (legal_hw[i]) begin
      r = lcg_next();
      send_word({r[31:16], legal_hw[i]});
    end
    idle_cycles(3);
    foreach (illegal_hw[i]) begin
      r = lcg_next();
      send_word({r[31:16], illegal_hw[i]});
    end
    send_word(32'h0000_8082);
    idle_cycles(2);
    send_word(32'hABCD_931E);
    idle_cycles(1);
    repeat (N_RANDOM) begin
      r = lcg_next();
      w[31:16] = r[31:16];
      r = lcg_next();
      w[15:0] = r[31:16];
      send_word(w);
    end
    idle_cycles(1);
    while (exp_q.size() != 0) @(posedge clk_i);
    repeat (2) @(posedge clk_i);
    report_and_finish();
  end

endmodule

//--- tb.f
+incdir+.
rv32i_isa_pkg.sv
rvc_pkg.sv
rvc_quadrant0_expander.sv
rvc_quadrant1_expander.sv
rvc_quadrant2_expander.sv
rvc_expander.sv
rvc_decode_stage.sv
tb_rvc_decode_stage.sv

//--- run.sh
#!/bin/sh
# Compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --assert --timing -f tb.f --top-module tb_rvc_decode_stage -o sim_rvc
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator compile failed with status $status"
  exit 1
fi

./obj_dir/sim_rvc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Result: PASSED$" "$LOG"; then
  exit 0
fi
exit 1
